//--- filelist.f
+incdir+hw
hw/autotest_pkg.sv
hw/block_seq_if.sv
hw/autotest_ctrl.sv
hw/vector_loader.sv
hw/exec_timer.sv
hw/result_packer.sv
hw/sd_autotest_top.sv
tb/sd_card_model.sv
tb/tb_sd_autotest.sv

//--- hw/autotest_ctrl.sv
/*
  autotest sequencer FSM
  resets the SD host, reads each test block, runs the UUT and
  writes the result block back, until a signature check fails
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module autotest_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   start_i,
  input  wire logic                   sd_busy_i,
  output logic                        sd_rst_o,
  output logic                        sd_rd_block_o,
  output logic                        sd_rd_byte_o,
  output logic                        sd_wr_block_o,
  output logic                        sd_wr_byte_o,
  output autotest_pkg::at_word_t      sd_block_addr_o,
  input  wire logic                   uut_end_i,
  output logic                        uut_rst_o,
  input  wire logic                   sig_ok_i,
  input  wire logic                   timeout_i,
  block_seq_if.ctrl                   seq
);

  localparam autotest_pkg::at_bidx_t LAST_IDX = autotest_pkg::at_bidx_t'(`AT_BLOCK_BYTES - 1);

  autotest_pkg::at_state_e state_q, state_d;
  autotest_pkg::at_bidx_t  byte_idx_q;
  autotest_pkg::at_word_t  block_addr_q;
  logic                    busy_seen_q;
  logic                    blk_start;
  logic                    byte_done;

  // sd_dout_i is valid in the first idle cycle after a byte command
  assign byte_done = !sd_busy_i &&
                     (state_q == autotest_pkg::RD_WAIT || state_q == autotest_pkg::WR_WAIT);
  assign blk_start = (state_q == autotest_pkg::HOST_WAIT && !sd_busy_i) ||
                     state_q == autotest_pkg::NEXT_BLOCK;

  always_comb begin
    state_d       = state_q;
    sd_rst_o      = 1'b0;
    sd_rd_block_o = 1'b0;
    sd_rd_byte_o  = 1'b0;
    sd_wr_block_o = 1'b0;
    sd_wr_byte_o  = 1'b0;
    case (state_q)
      autotest_pkg::WAIT_START: begin
        if (start_i) state_d = autotest_pkg::HOST_RST;
      end
      autotest_pkg::HOST_RST: begin
        sd_rst_o = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::HOST_WAIT;
      end
      autotest_pkg::HOST_WAIT: begin
        if (!sd_busy_i) state_d = autotest_pkg::RD_BLOCK;
      end
      autotest_pkg::RD_BLOCK: begin
        sd_rd_block_o = 1'b1;
        if (busy_seen_q && !sd_busy_i) state_d = autotest_pkg::RD_BYTE;
      end
      autotest_pkg::RD_BYTE: begin
        sd_rd_block_o = 1'b1;
        sd_rd_byte_o  = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::RD_WAIT;
      end
      autotest_pkg::RD_WAIT: begin
        sd_rd_block_o = 1'b1;
        if (!sd_busy_i) begin
          state_d = (byte_idx_q == LAST_IDX) ? autotest_pkg::CHECK_SIG : autotest_pkg::RD_BYTE;
        end
      end
      autotest_pkg::CHECK_SIG: begin
        state_d = sig_ok_i ? autotest_pkg::RUN : autotest_pkg::WAIT_START;
      end
      autotest_pkg::RUN: begin
        if (uut_end_i || timeout_i) state_d = autotest_pkg::COMPARE;
      end
      autotest_pkg::COMPARE: begin
        state_d = autotest_pkg::WR_BLOCK;
      end
      autotest_pkg::WR_BLOCK: begin
        sd_wr_block_o = 1'b1;
        if (busy_seen_q && !sd_busy_i) state_d = autotest_pkg::WR_BYTE;
      end
      autotest_pkg::WR_BYTE: begin
        sd_wr_block_o = 1'b1;
        sd_wr_byte_o  = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::WR_WAIT;
      end
      autotest_pkg::WR_WAIT: begin
        sd_wr_block_o = 1'b1;
        if (!sd_busy_i) begin
          state_d = (byte_idx_q == LAST_IDX) ? autotest_pkg::NEXT_BLOCK : autotest_pkg::WR_BYTE;
        end
      end
      autotest_pkg::NEXT_BLOCK: begin
        state_d = autotest_pkg::RD_BLOCK;
      end
      default: state_d = autotest_pkg::WAIT_START;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= autotest_pkg::WAIT_START;
      byte_idx_q   <= '0;
      block_addr_q <= `AT_START_BLOCK;
      busy_seen_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (blk_start || state_q == autotest_pkg::COMPARE) begin
        byte_idx_q <= '0;
      end else if (byte_done) begin
        byte_idx_q <= byte_idx_q + 1'b1;
      end
      if (state_q == autotest_pkg::WAIT_START && start_i) begin
        block_addr_q <= `AT_START_BLOCK;
      end else if (state_q == autotest_pkg::NEXT_BLOCK) begin
        block_addr_q <= block_addr_q + 32'd1;
      end
      // block command busy phase, cleared on every state change
      if (state_d != state_q) begin
        busy_seen_q <= 1'b0;
      end else if (sd_busy_i) begin
        busy_seen_q <= 1'b1;
      end
    end
  end

  assign sd_block_addr_o = block_addr_q;
  assign uut_rst_o       = (state_q != autotest_pkg::RUN);
  assign seq.byte_idx    = byte_idx_q;
  assign seq.rx_strobe   = byte_done && state_q == autotest_pkg::RD_WAIT;
  assign seq.clear       = blk_start;
  assign seq.compare     = (state_q == autotest_pkg::COMPARE);

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(sd_rd_block_o && sd_wr_block_o));

  a_idx_range: assert property (@(posedge clk) disable iff (rst)
    byte_idx_q <= `AT_BLOCK_BYTES);

endmodule

`default_nettype wire

//--- hw/autotest_defines.svh
/*
  SD autotest parameters
  block layout offsets, signature, first block and execution limit
*/
`ifndef AUTOTEST_DEFINES_SVH
`define AUTOTEST_DEFINES_SVH

`define AT_BLOCK_BYTES  512
`define AT_OPND_BYTES   4
`define AT_RES_BYTES    4

// read block fields
`define AT_SIG_OFS      0
`define AT_A_OFS        4
`define AT_B_OFS        8
`define AT_EXP_OFS      12

// written block fields
`define AT_WR_RES_OFS   0
`define AT_WR_TIME_OFS  4

`define AT_SIGNATURE    32'hAABBCCDD
`define AT_START_BLOCK  32'h0010_0000
`define AT_TIMEOUT      2000
`define AT_PAD_BYTE     8'hFF

`endif

//--- hw/autotest_pkg.sv
/*
  SD autotest shared types
  data words, byte index and the sequencer states
*/
`default_nettype none

package autotest_pkg;

  typedef logic [7:0]  at_byte_t;
  typedef logic [31:0] at_word_t;
  typedef logic [31:0] at_cycles_t;
  // 0 to 512 inclusive
  typedef logic [9:0]  at_bidx_t;

  typedef enum logic [3:0] {
    WAIT_START, HOST_RST, HOST_WAIT,
    RD_BLOCK, RD_BYTE, RD_WAIT, CHECK_SIG,
    RUN, COMPARE,
    WR_BLOCK, WR_BYTE, WR_WAIT, NEXT_BLOCK
  } at_state_e;

endpackage

`default_nettype wire

//--- hw/block_seq_if.sv
/*
  block sequencing bundle
  byte position and per-block strobes from controller to datapath
*/
`timescale 1ns/1ns
`default_nettype none

interface block_seq_if;
  autotest_pkg::at_bidx_t byte_idx;
  logic                   rx_strobe;
  logic                   clear;
  logic                   compare;

  modport ctrl (output byte_idx, rx_strobe, clear, compare);
  modport dp (input byte_idx, rx_strobe, clear, compare);
endinterface

`default_nettype wire

//--- hw/exec_timer.sv
/*
  UUT execution timer
  counts run cycles until the UUT ends, saturating at the timeout
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module exec_timer (
  input  wire logic                clk,
  input  wire logic                rst,
  block_seq_if.dp                  seq,
  input  wire logic                running_i,
  input  wire logic                uut_end_i,
  output autotest_pkg::at_cycles_t cycles_o,
  output logic                     timeout_o
);

  autotest_pkg::at_cycles_t cnt_q;

  always_ff @(posedge clk) begin
    if (rst || seq.clear) begin
      cnt_q <= '0;
    end else if (running_i && !uut_end_i && !timeout_o) begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  assign cycles_o  = cnt_q;
  assign timeout_o = (cnt_q == `AT_TIMEOUT);

  a_cnt_sat: assert property (@(posedge clk) disable iff (rst)
    cnt_q <= `AT_TIMEOUT);

endmodule

`default_nettype wire

//--- hw/result_packer.sv
/*
  result packer
  latches the UUT result, counts mismatches and serves the
  bytes of the result block being written
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module result_packer (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      start_i,
  block_seq_if.dp                        seq,
  input  wire autotest_pkg::at_word_t    uut_result_i,
  input  wire autotest_pkg::at_word_t    expected_i,
  input  wire autotest_pkg::at_cycles_t  cycles_i,
  output autotest_pkg::at_byte_t         tx_byte_o,
  output autotest_pkg::at_word_t         error_count_o
);

  localparam int TIME_BYTES = $bits(autotest_pkg::at_cycles_t) / 8;

  autotest_pkg::at_word_t result_q;
  autotest_pkg::at_word_t err_q;
  autotest_pkg::at_bidx_t rel_res, rel_time;

  always_ff @(posedge clk) begin
    if (seq.compare) result_q <= uut_result_i;
  end

  always_ff @(posedge clk) begin
    if (rst || start_i) begin
      err_q <= '0;
    end else if (seq.compare && uut_result_i != expected_i) begin
      err_q <= err_q + 32'd1;
    end
  end

  assign rel_res  = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_WR_RES_OFS);
  assign rel_time = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_WR_TIME_OFS);

  // result then cycle count, both lsb first, pad elsewhere
  always_comb begin
    tx_byte_o = `AT_PAD_BYTE;
    if (rel_res < `AT_RES_BYTES) begin
      tx_byte_o = result_q[8*rel_res[1:0] +: 8];
    end else if (rel_time < TIME_BYTES) begin
      tx_byte_o = cycles_i[8*rel_time[1:0] +: 8];
    end
  end

  assign error_count_o = err_q;

endmodule

`default_nettype wire

//--- hw/sd_autotest_top.sv
/*
  SD card autotest top
  sequencer plus vector, timer and result datapath for one UUT
*/
`timescale 1ns/1ns
`default_nettype none

module sd_autotest_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    start_i,
  output logic                         sd_rst_o,
  output logic                         sd_rd_block_o,
  output logic                         sd_rd_byte_o,
  output logic                         sd_wr_block_o,
  output logic                         sd_wr_byte_o,
  output autotest_pkg::at_word_t       sd_block_addr_o,
  input  wire logic                    sd_busy_i,
  input  wire autotest_pkg::at_byte_t  sd_dout_i,
  output autotest_pkg::at_byte_t       sd_din_o,
  output logic                         uut_rst_o,
  output autotest_pkg::at_word_t       uut_a_o,
  output autotest_pkg::at_word_t       uut_b_o,
  input  wire autotest_pkg::at_word_t  uut_result_i,
  input  wire logic                    uut_end_i,
  output autotest_pkg::at_word_t       error_count_o
);

  autotest_pkg::at_word_t   expected;
  autotest_pkg::at_cycles_t cycles;
  logic                     sig_ok;
  logic                     timeout;
  logic                     running;

  block_seq_if seq_if ();

  assign running = ~uut_rst_o;

  autotest_ctrl ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .start_i         (start_i),
    .sd_busy_i       (sd_busy_i),
    .sd_rst_o        (sd_rst_o),
    .sd_rd_block_o   (sd_rd_block_o),
    .sd_rd_byte_o    (sd_rd_byte_o),
    .sd_wr_block_o   (sd_wr_block_o),
    .sd_wr_byte_o    (sd_wr_byte_o),
    .sd_block_addr_o (sd_block_addr_o),
    .uut_end_i       (uut_end_i),
    .uut_rst_o       (uut_rst_o),
    .sig_ok_i        (sig_ok),
    .timeout_i       (timeout),
    .seq             (seq_if.ctrl)
  );

  vector_loader loader_i (
    .clk        (clk),
    .rst        (rst),
    .seq        (seq_if.dp),
    .sd_dout_i  (sd_dout_i),
    .uut_a_o    (uut_a_o),
    .uut_b_o    (uut_b_o),
    .expected_o (expected),
    .sig_ok_o   (sig_ok)
  );

  exec_timer timer_i (
    .clk       (clk),
    .rst       (rst),
    .seq       (seq_if.dp),
    .running_i (running),
    .uut_end_i (uut_end_i),
    .cycles_o  (cycles),
    .timeout_o (timeout)
  );

  result_packer packer_i (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start_i),
    .seq           (seq_if.dp),
    .uut_result_i  (uut_result_i),
    .expected_i    (expected),
    .cycles_i      (cycles),
    .tx_byte_o     (sd_din_o),
    .error_count_o (error_count_o)
  );

endmodule

`default_nettype wire

//--- hw/vector_loader.sv
/*
  test vector loader
  assembles signature, operands and expected result from block bytes
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module vector_loader (
  input  wire logic                    clk,
  input  wire logic                    rst,
  block_seq_if.dp                      seq,
  input  wire autotest_pkg::at_byte_t  sd_dout_i,
  output autotest_pkg::at_word_t       uut_a_o,
  output autotest_pkg::at_word_t       uut_b_o,
  output autotest_pkg::at_word_t       expected_o,
  output logic                         sig_ok_o
);

  localparam int SIG_BYTES = $bits(autotest_pkg::at_word_t) / 8;

  autotest_pkg::at_word_t sig_q;
  autotest_pkg::at_word_t a_q;
  autotest_pkg::at_word_t b_q;
  autotest_pkg::at_word_t exp_q;
  // positions relative to each field, wrap makes out-of-field values large
  autotest_pkg::at_bidx_t rel_sig, rel_a, rel_b, rel_exp;

  assign rel_sig = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_SIG_OFS);
  assign rel_a   = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_A_OFS);
  assign rel_b   = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_B_OFS);
  assign rel_exp = seq.byte_idx - autotest_pkg::at_bidx_t'(`AT_EXP_OFS);

  always_ff @(posedge clk) begin
    if (rst || seq.clear) begin
      sig_q <= '0;
      a_q   <= '0;
      b_q   <= '0;
      exp_q <= '0;
    end else if (seq.rx_strobe) begin
      // signature arrives msb first, the rest lsb first
      if (rel_sig < SIG_BYTES) sig_q[8*(SIG_BYTES-1-rel_sig[1:0]) +: 8] <= sd_dout_i;
      if (rel_a < `AT_OPND_BYTES) a_q[8*rel_a[1:0] +: 8] <= sd_dout_i;
      if (rel_b < `AT_OPND_BYTES) b_q[8*rel_b[1:0] +: 8] <= sd_dout_i;
      if (rel_exp < `AT_RES_BYTES) exp_q[8*rel_exp[1:0] +: 8] <= sd_dout_i;
    end
  end

  assign uut_a_o    = a_q;
  assign uut_b_o    = b_q;
  assign expected_o = exp_q;
  assign sig_ok_o   = (sig_q == `AT_SIGNATURE);

  a_no_strobe_past_end: assert property (@(posedge clk) disable iff (rst)
    !(seq.rx_strobe && seq.byte_idx == `AT_BLOCK_BYTES));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass message is printed
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_sd_autotest -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/sd_card_model.sv
/*
  behavioral SD host model
  block storage, random busy timing per command and write capture
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module sd_card_model #(
  parameter int BLOCKS = 8
) (
  input  wire logic                    clk,
  input  wire logic                    rst_cmd_i,
  input  wire logic                    rd_block_i,
  input  wire logic                    rd_byte_i,
  input  wire logic                    wr_block_i,
  input  wire logic                    wr_byte_i,
  input  wire autotest_pkg::at_word_t  block_addr_i,
  input  wire autotest_pkg::at_byte_t  din_i,
  output logic                         busy_o,
  output autotest_pkg::at_byte_t       dout_o
);

  autotest_pkg::at_byte_t mem    [BLOCKS * `AT_BLOCK_BYTES];
  autotest_pkg::at_byte_t wr_buf [BLOCKS * `AT_BLOCK_BYTES];
  autotest_pkg::at_word_t rd_log [16];
  autotest_pkg::at_word_t wr_log [16];
  int rd_cmds;
  int wr_cmds;
  int rd_done;
  int wr_done;
  int base;
  int idx;
  int delay;
  int hold;
  // rst, rd_block, rd_byte, wr_block, wr_byte
  logic [4:0] cmd_now;
  logic [4:0] cmd_last;
  logic [4:0] rise;

  task sample_cycle();
    @(posedge clk);
    #1;
    cmd_last = cmd_now;
    cmd_now  = {rst_cmd_i, rd_block_i, rd_byte_i, wr_block_i, wr_byte_i};
  endtask

  function int block_base(input autotest_pkg::at_word_t addr);
    autotest_pkg::at_word_t slot;
    slot = (addr - `AT_START_BLOCK) % BLOCKS;
    return int'(slot) * `AT_BLOCK_BYTES;
  endfunction

  initial begin
    busy_o   = 1'b0;
    dout_o   = '0;
    cmd_now  = '0;
    cmd_last = '0;
    rd_cmds  = 0;
    wr_cmds  = 0;
    rd_done  = 0;
    wr_done  = 0;
    base     = 0;
    idx      = 0;
    forever begin
      sample_cycle();
      rise = cmd_now & ~cmd_last;
      if (rise != '0) begin
        delay = $urandom_range(4, 1);
        hold  = $urandom_range(6, 1);
        repeat (delay) sample_cycle();
        busy_o = 1'b1;
        if (rise[3]) begin
          rd_log[rd_cmds % 16] = block_addr_i;
          rd_cmds++;
          base = block_base(block_addr_i);
          idx  = 0;
        end
        if (rise[1]) begin
          wr_log[wr_cmds % 16] = block_addr_i;
          wr_cmds++;
          base = block_base(block_addr_i);
          idx  = 0;
        end
        if (rise[0]) begin
          // din holds from the command until busy falls
          wr_buf[base + idx] = din_i;
          idx++;
          if (idx == `AT_BLOCK_BYTES) wr_done++;
        end
        repeat (hold) sample_cycle();
        if (rise[2]) begin
          dout_o = mem[base + idx];
          idx++;
          if (idx == `AT_BLOCK_BYTES) rd_done++;
        end
        busy_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_sd_autotest.sv
/*
  SD autotest testbench
  random test blocks on a card model, an adder UUT model with one
  hung run, and checks of every written block and the error count
*/
`timescale 1ns/1ns
`default_nettype none
`include "autotest_defines.svh"

module tb_sd_autotest;

  localparam int N_BLOCKS    = 6;
  localparam int MEM_BLOCKS  = 8;
  localparam int HANG_BLOCK  = 2;
  localparam int CYCLE_LIMIT = N_BLOCKS * (2 * `AT_BLOCK_BYTES * 12 + `AT_TIMEOUT) + 1000;

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic                   sd_rst;
  logic                   sd_rd_block;
  logic                   sd_rd_byte;
  logic                   sd_wr_block;
  logic                   sd_wr_byte;
  autotest_pkg::at_word_t sd_block_addr;
  logic                   sd_busy;
  autotest_pkg::at_byte_t sd_dout;
  autotest_pkg::at_byte_t sd_din;
  logic                   uut_rst;
  autotest_pkg::at_word_t uut_a;
  autotest_pkg::at_word_t uut_b;
  autotest_pkg::at_word_t uut_result;
  logic                   uut_end;
  autotest_pkg::at_word_t error_count;

  autotest_pkg::at_word_t   a_mem      [N_BLOCKS];
  autotest_pkg::at_word_t   b_mem      [N_BLOCKS];
  autotest_pkg::at_word_t   exp_mem    [N_BLOCKS];
  autotest_pkg::at_cycles_t cycles_log [N_BLOCKS];
  autotest_pkg::at_word_t   exp_errs;
  int   run_cycles;
  int   end_wait;
  int   run_blk;
  int   runs_seen;
  logic run_active;
  int   cycle_cnt;

  // adder UUT
  assign uut_result = uut_a + uut_b;

  sd_autotest_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .start_i         (start),
    .sd_rst_o        (sd_rst),
    .sd_rd_block_o   (sd_rd_block),
    .sd_rd_byte_o    (sd_rd_byte),
    .sd_wr_block_o   (sd_wr_block),
    .sd_wr_byte_o    (sd_wr_byte),
    .sd_block_addr_o (sd_block_addr),
    .sd_busy_i       (sd_busy),
    .sd_dout_i       (sd_dout),
    .sd_din_o        (sd_din),
    .uut_rst_o       (uut_rst),
    .uut_a_o         (uut_a),
    .uut_b_o         (uut_b),
    .uut_result_i    (uut_result),
    .uut_end_i       (uut_end),
    .error_count_o   (error_count)
  );

  sd_card_model #(.BLOCKS(MEM_BLOCKS)) card_i (
    .clk          (clk),
    .rst_cmd_i    (sd_rst),
    .rd_block_i   (sd_rd_block),
    .rd_byte_i    (sd_rd_byte),
    .wr_block_i   (sd_wr_block),
    .wr_byte_i    (sd_wr_byte),
    .block_addr_i (sd_block_addr),
    .din_i        (sd_din),
    .busy_o       (sd_busy),
    .dout_o       (sd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task next_cycle();
    @(posedge clk);
    #1;
  endtask

  task word_check(input string name, input autotest_pkg::at_word_t exp,
                  input autotest_pkg::at_word_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task cycles_check(input string name, input autotest_pkg::at_cycles_t exp,
                    input autotest_pkg::at_cycles_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %0d actual %0d", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "cycle count mismatch");
    end
  endtask

  task byte_check(input string name, input autotest_pkg::at_byte_t exp,
                  input autotest_pkg::at_byte_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "byte mismatch");
    end
  endtask

  task level_check(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "level mismatch");
    end
  endtask

  task idle_check(input string name);
    level_check({name, " sd_rst"}, 1'b0, sd_rst);
    level_check({name, " sd_rd_block"}, 1'b0, sd_rd_block);
    level_check({name, " sd_rd_byte"}, 1'b0, sd_rd_byte);
    level_check({name, " sd_wr_block"}, 1'b0, sd_wr_block);
    level_check({name, " sd_wr_byte"}, 1'b0, sd_wr_byte);
    level_check({name, " uut_rst"}, 1'b1, uut_rst);
  endtask

  task load_blocks();
    autotest_pkg::at_word_t sig;
    autotest_pkg::at_word_t sum;
    int base;
    for (int i = 0; i < MEM_BLOCKS * `AT_BLOCK_BYTES; i++) begin
      card_i.mem[i] = autotest_pkg::at_byte_t'($urandom);
    end
    for (int blk = 0; blk < N_BLOCKS; blk++) begin
      a_mem[blk] = $urandom;
      b_mem[blk] = $urandom;
      sum = a_mem[blk] + b_mem[blk];
      exp_mem[blk] = sum;
      // one in three blocks carries a wrong expected value
      if ($urandom_range(2, 0) == 0) exp_mem[blk] = sum ^ (32'h1 << $urandom_range(31, 0));
      sig = (blk == N_BLOCKS - 1) ? (`AT_SIGNATURE ^ 32'h0000_5A00) : `AT_SIGNATURE;
      base = blk * `AT_BLOCK_BYTES;
      for (int k = 0; k < 4; k++) begin
        card_i.mem[base + `AT_SIG_OFS + k] = sig[8*(3-k) +: 8];
        card_i.mem[base + `AT_A_OFS + k]   = a_mem[blk][8*k +: 8];
        card_i.mem[base + `AT_B_OFS + k]   = b_mem[blk][8*k +: 8];
        card_i.mem[base + `AT_EXP_OFS + k] = exp_mem[blk][8*k +: 8];
      end
    end
  endtask

  task written_check(input int blk);
    autotest_pkg::at_word_t   sum;
    autotest_pkg::at_word_t   got_res;
    autotest_pkg::at_cycles_t cyc;
    autotest_pkg::at_cycles_t got_cyc;
    int base;
    sum  = a_mem[blk] + b_mem[blk];
    cyc  = (cycles_log[blk] > `AT_TIMEOUT) ? `AT_TIMEOUT : cycles_log[blk];
    base = blk * `AT_BLOCK_BYTES;
    word_check("write address", `AT_START_BLOCK + blk, card_i.wr_log[blk]);
    for (int k = 0; k < 4; k++) begin
      got_res[8*k +: 8] = card_i.wr_buf[base + `AT_WR_RES_OFS + k];
      got_cyc[8*k +: 8] = card_i.wr_buf[base + `AT_WR_TIME_OFS + k];
    end
    word_check($sformatf("block %0d result", blk), sum, got_res);
    cycles_check($sformatf("block %0d cycles", blk), cyc, got_cyc);
    for (int i = `AT_WR_TIME_OFS + 4; i < `AT_BLOCK_BYTES; i++) begin
      byte_check($sformatf("block %0d pad byte %0d", blk, i), `AT_PAD_BYTE,
                 card_i.wr_buf[base + i]);
    end
  endtask

  task pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  // UUT timing model and run cycle count
  initial begin
    uut_end    = 1'b0;
    run_active = 1'b0;
    run_cycles = 0;
    end_wait   = 0;
    run_blk    = 0;
    runs_seen  = 0;
    forever begin
      next_cycle();
      if (uut_rst) begin
        if (run_active) cycles_log[run_blk] = run_cycles;
        run_active = 1'b0;
        uut_end    = 1'b0;
      end else begin
        if (!run_active) begin
          run_active = 1'b1;
          run_cycles = 0;
          word_check("run block address", `AT_START_BLOCK + runs_seen, sd_block_addr);
          run_blk = int'(sd_block_addr - `AT_START_BLOCK);
          word_check($sformatf("block %0d operand a", run_blk), a_mem[run_blk], uut_a);
          word_check($sformatf("block %0d operand b", run_blk), b_mem[run_blk], uut_b);
          runs_seen++;
          end_wait = (run_blk == HANG_BLOCK) ? 32'h7FFF_FFFF : $urandom_range(60, 5);
        end
        if (!uut_end) begin
          if (run_cycles == end_wait) uut_end = 1'b1;
          else run_cycles++;
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run hung: cycle limit of %0d reached", CYCLE_LIMIT);
    $display("TB FAILED");
    $fatal(1, "cycle limit");
  end

  initial begin
    void'($urandom(54544));
    rst      = 1'b1;
    start    = 1'b0;
    exp_errs = '0;
    load_blocks();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_check("after reset");
    word_check("error count after reset", 32'd0, error_count);
    pulse_start();

    for (int blk = 0; blk < N_BLOCKS - 1; blk++) begin
      while (card_i.wr_done < blk + 1) next_cycle();
      word_check("read address", `AT_START_BLOCK + blk, card_i.rd_log[blk]);
      written_check(blk);
      if (exp_mem[blk] != a_mem[blk] + b_mem[blk]) exp_errs++;
      word_check($sformatf("error count after block %0d", blk), exp_errs, error_count);
    end

    // wait out the bad signature block and the CHECK_SIG cycle
    while (card_i.rd_done < N_BLOCKS) next_cycle();
    word_check("bad block read address", `AT_START_BLOCK + N_BLOCKS - 1,
               card_i.rd_log[N_BLOCKS - 1]);
    while (sd_rd_block) next_cycle();
    next_cycle();
    repeat (20) begin
      idle_check("after bad signature");
      next_cycle();
    end
    word_check("write commands", autotest_pkg::at_word_t'(N_BLOCKS - 1),
               autotest_pkg::at_word_t'(card_i.wr_cmds));

    pulse_start();
    word_check("error count after restart", 32'd0, error_count);
    while (card_i.rd_cmds < N_BLOCKS + 1) next_cycle();
    word_check("restart read address", `AT_START_BLOCK, card_i.rd_log[N_BLOCKS]);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
